/* hdl/lite_mips_defs.svh */
`ifndef LITE_MIPS_DEFS_SVH
`define LITE_MIPS_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Core dimensions
// ~~~~~~~~~~~~~~~~~~~~
`define LM_WORD_BITS 32         // Machine word, fixed by the ISA
`define LM_MEM_ADDR_BITS 6      // 64 words in each memory
`define LM_RESET_PC 32'h0000_0000

`endif

/* hdl/lite_mips_pkg.sv */
`include "lite_mips_defs.svh"

package lite_mips_pkg;

	typedef logic [`LM_WORD_BITS-1:0] word_t;

	// ~~~~~~~~~~~~~~~~~~~~
	// Datapath selects
	// ~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [3:0] {
		alu_none,           // Drives a zero result
		alu_add, alu_sub,
		alu_and, alu_or, alu_xor, alu_nor,
		alu_slt, alu_sltu,
		alu_sll, alu_srl, alu_sra,
		alu_lui
	} alu_func_t;

	typedef enum logic [1:0] {
		a_sel_reg_source, a_sel_shamt, a_sel_zero
	} a_source_t;

	typedef enum logic [1:0] {
		b_sel_reg_target, b_sel_sign_imm, b_sel_zero_imm
	} b_source_t;

	typedef enum logic [1:0] {
		c_sel_alu, c_sel_memory, c_sel_pc_plus4
	} c_source_t;

	typedef enum logic [1:0] {
		pc_sel_plus4, pc_sel_branch, pc_sel_jump, pc_sel_register
	} pc_source_t;

	typedef enum logic [1:0] {
		branch_none, branch_eq, branch_ne
	} branch_func_t;

	typedef enum logic [1:0] {
		mem_none, mem_read_word, mem_write_word
	} mem_source_t;

endpackage

/* hdl/fetch_unit.sv */
`timescale 1ns/100ps
`include "lite_mips_defs.svh"

module fetch_unit import lite_mips_pkg::*; #(
	parameter int L = `LM_MEM_ADDR_BITS
) (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [(2**L)*`LM_WORD_BITS-1:0]   inst_mem_in_wire,
	input  logic                              take_branch,
	input  pc_source_t                        pc_source,
	input  word_t                             reg_source,
	output word_t                             instr,
	output word_t                             pc_plus4
);

	word_t pc;
	word_t branch_target;
	word_t jump_target;
	word_t pc_next;

	assign instr = inst_mem_in_wire[pc[L+1:2]*`LM_WORD_BITS +: `LM_WORD_BITS];
	assign pc_plus4 = pc + 32'd4;
	assign branch_target = pc_plus4 + {{14{instr[15]}}, instr[15:0], 2'b00};
	assign jump_target = {pc_plus4[31:28], instr[25:0], 2'b00};    // Stays in the current 256 MB region

	always_comb begin
		case (pc_source)
			pc_sel_branch:   pc_next = take_branch ? branch_target : pc_plus4;
			pc_sel_jump:     pc_next = jump_target;
			pc_sel_register: pc_next = reg_source;
			default:         pc_next = pc_plus4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= `LM_RESET_PC;
		end else begin
			pc <= pc_next;
		end
	end

	// Every PC that follows a running cycle must address a word of the program
	pc_in_range: assert property (@(posedge clk) rst_n |=>
		(pc[1:0] == 2'b00 && pc[`LM_WORD_BITS-1:L+2] == '0))
		else $error("PC %h left the instruction memory", pc);

endmodule

/* hdl/control.sv */
`timescale 1ns/100ps

module control import lite_mips_pkg::*; (
	input  word_t         instr,
	output logic [4:0]    rs_index,
	output logic [4:0]    rt_index,
	output logic [4:0]    rd_index,
	output logic [15:0]   imm,
	output alu_func_t     alu_func,
	output a_source_t     a_source,
	output b_source_t     b_source,
	output c_source_t     c_source,
	output pc_source_t    pc_source,
	output branch_func_t  branch_func,
	output mem_source_t   mem_source,
	output logic          reg_write
);

	logic [5:0] opcode;
	logic [5:0] funct;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign rs_index = instr[25:21];
	assign rt_index = instr[20:16];
	assign imm = instr[15:0];

	always_comb begin
		rd_index = (opcode == 6'h00) ? instr[15:11] : instr[20:16];
		alu_func = alu_none;
		a_source = a_sel_reg_source;
		b_source = b_sel_reg_target;
		c_source = c_sel_alu;
		pc_source = pc_sel_plus4;
		branch_func = branch_none;
		mem_source = mem_none;
		reg_write = 1'b0;
		case (opcode)
			6'h00: begin
				reg_write = 1'b1;
				if (funct[5:2] == 4'd0) begin
					a_source = a_sel_shamt;     // Fixed shifts take the amount from the word
				end
				case (funct)
					6'h00, 6'h04: alu_func = alu_sll;
					6'h02, 6'h06: alu_func = alu_srl;
					6'h03, 6'h07: alu_func = alu_sra;
					6'h21:        alu_func = alu_add;
					6'h23:        alu_func = alu_sub;
					6'h24:        alu_func = alu_and;
					6'h25:        alu_func = alu_or;
					6'h26:        alu_func = alu_xor;
					6'h27:        alu_func = alu_nor;
					6'h2a:        alu_func = alu_slt;
					6'h2b:        alu_func = alu_sltu;
					6'h08: begin
						reg_write = 1'b0;
						pc_source = pc_sel_register;
					end
					default:      reg_write = 1'b0;
				endcase
			end
			6'h02: pc_source = pc_sel_jump;
			6'h03: begin
				pc_source = pc_sel_jump;
				rd_index = 5'd31;               // Link register
				c_source = c_sel_pc_plus4;
				reg_write = 1'b1;
			end
			6'h04, 6'h05: begin
				branch_func = opcode[0] ? branch_ne : branch_eq;
				pc_source = pc_sel_branch;
			end
			6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
				reg_write = 1'b1;
				b_source = opcode[2] ? b_sel_zero_imm : b_sel_sign_imm;  // Logic ops zero-extend
				case (opcode[2:0])
					3'd1:    alu_func = alu_add;
					3'd2:    alu_func = alu_slt;
					3'd3:    alu_func = alu_sltu;
					3'd4:    alu_func = alu_and;
					3'd5:    alu_func = alu_or;
					3'd6:    alu_func = alu_xor;
					default: begin
						alu_func = alu_lui;
						a_source = a_sel_zero;
					end
				endcase
			end
			6'h23: begin
				alu_func = alu_add;
				b_source = b_sel_sign_imm;
				c_source = c_sel_memory;
				mem_source = mem_read_word;
				reg_write = 1'b1;
			end
			6'h2b: begin
				alu_func = alu_add;
				b_source = b_sel_sign_imm;
				mem_source = mem_write_word;
			end
			default: ;                          // Unsupported opcodes fall through as a nop
		endcase
	end

endmodule

/* hdl/reg_bank.sv */
`timescale 1ns/100ps

module reg_bank import lite_mips_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [4:0]  rs_index,
	input  logic [4:0]  rt_index,
	input  logic [4:0]  rd_index,
	input  logic        reg_write,
	input  word_t       reg_dest,
	output word_t       reg_source,
	output word_t       reg_target
);

	word_t regs [1:31];     // Register 0 has no storage

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (reg_write && rd_index != 5'd0) begin
			regs[rd_index] <= reg_dest;
		end
	end

	assign reg_source = (rs_index == 5'd0) ? '0 : regs[rs_index];
	assign reg_target = (rt_index == 5'd0) ? '0 : regs[rt_index];

	// A written value reads back on the next cycle, and a write aimed at register 0 reads as zero
	write_read_back: assert property (@(posedge clk) disable iff (!rst_n)
		reg_write |=> (rs_index != $past(rd_index)
			|| reg_source == (($past(rd_index) == 5'd0) ? '0 : $past(reg_dest))))
		else $error("Register %0d did not read back its last write", rs_index);

endmodule

/* hdl/bus_mux.sv */
`timescale 1ns/100ps

module bus_mux import lite_mips_pkg::*; (
	input  logic [15:0]   imm,
	input  logic [4:0]    shamt,
	input  word_t         reg_source,
	input  word_t         reg_target,
	input  a_source_t     a_source,
	input  b_source_t     b_source,
	input  word_t         c_alu,
	input  word_t         mem_data,
	input  word_t         pc_plus4,
	input  c_source_t     c_source,
	input  branch_func_t  branch_func,
	output word_t         a_bus,
	output word_t         b_bus,
	output word_t         reg_dest,
	output logic          take_branch
);

	always_comb begin
		case (a_source)
			a_sel_shamt: a_bus = {27'd0, shamt};
			a_sel_zero:  a_bus = '0;
			default:     a_bus = reg_source;
		endcase
		case (b_source)
			b_sel_sign_imm: b_bus = {{16{imm[15]}}, imm};
			b_sel_zero_imm: b_bus = {16'd0, imm};
			default:        b_bus = reg_target;
		endcase
		case (c_source)
			c_sel_memory:   reg_dest = mem_data;
			c_sel_pc_plus4: reg_dest = pc_plus4;    // Return address for jal
			default:        reg_dest = c_alu;
		endcase
		case (branch_func)
			branch_eq: take_branch = (reg_source == reg_target);
			branch_ne: take_branch = (reg_source != reg_target);
			default:   take_branch = 1'b0;
		endcase
	end

endmodule

/* hdl/alu.sv */
`timescale 1ns/100ps

module alu import lite_mips_pkg::*; (
	input  word_t      a_bus,
	input  word_t      b_bus,
	input  alu_func_t  alu_func,
	output word_t      c_alu
);

	logic [4:0] shift_amount;
	logic       less_signed;
	logic       less_unsigned;

	assign shift_amount = a_bus[4:0];     // Upper bits of rs are ignored for variable shifts
	assign less_signed = $signed(a_bus) < $signed(b_bus);
	assign less_unsigned = a_bus < b_bus;

	always_comb begin
		case (alu_func)
			// ~~~~~~~~~~~~~~~~~~~~
			// Arithmetic and logic
			// ~~~~~~~~~~~~~~~~~~~~
			alu_add:  c_alu = a_bus + b_bus;
			alu_sub:  c_alu = a_bus - b_bus;
			alu_and:  c_alu = a_bus & b_bus;
			alu_or:   c_alu = a_bus | b_bus;
			alu_xor:  c_alu = a_bus ^ b_bus;
			alu_nor:  c_alu = ~(a_bus | b_bus);
			alu_slt:  c_alu = {31'd0, less_signed};
			alu_sltu: c_alu = {31'd0, less_unsigned};
			alu_lui:  c_alu = {b_bus[15:0], 16'd0};
			// ~~~~~~~~~~~~~~~~~~~~
			// Shifts of operand B
			// ~~~~~~~~~~~~~~~~~~~~
			alu_sll:  c_alu = b_bus << shift_amount;
			alu_srl:  c_alu = b_bus >> shift_amount;
			alu_sra:  c_alu = $signed(b_bus) >>> shift_amount;   // Sign bit fills from the left
			default:  c_alu = '0;
		endcase
	end

endmodule

/* hdl/data_mem.sv */
`timescale 1ns/100ps
`include "lite_mips_defs.svh"

module data_mem import lite_mips_pkg::*; #(
	parameter int L = `LM_MEM_ADDR_BITS
) (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [(2**L)*`LM_WORD_BITS-1:0]   data_mem_in_wire,
	input  word_t                             addr,
	input  word_t                             data_in,
	input  mem_source_t                       mem_source,
	output word_t                             mem_data,
	output logic [(2**L)*`LM_WORD_BITS-1:0]   data_mem_out_wire
);

	localparam int N = 2**L;

	word_t      mem [N];
	logic [L-1:0] index;

	assign index = addr[L+1:2];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int k = 0; k < N; k++) begin
				mem[k] <= data_mem_in_wire[k*`LM_WORD_BITS +: `LM_WORD_BITS];
			end
		end else if (mem_source == mem_write_word) begin
			mem[index] <= data_in;
		end
	end

	assign mem_data = (mem_source == mem_read_word) ? mem[index] : '0;

	for (genvar g = 0; g < N; g++) begin : g_mirror
		assign data_mem_out_wire[g*`LM_WORD_BITS +: `LM_WORD_BITS] = mem[g];
	end

	// The ALU result used as address must land on a stored word
	access_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		(mem_source != mem_none) |-> (addr[1:0] == 2'b00 && addr[`LM_WORD_BITS-1:L+2] == '0))
		else $error("Data access at bad address %h", addr);

endmodule

/* hdl/lite_mips.sv */
`timescale 1ns/100ps
`include "lite_mips_defs.svh"

module lite_mips import lite_mips_pkg::*; #(
	parameter int L = `LM_MEM_ADDR_BITS
) (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [(2**L)*`LM_WORD_BITS-1:0]   inst_mem_in_wire,
	input  logic [(2**L)*`LM_WORD_BITS-1:0]   data_mem_in_wire,
	output logic [(2**L)*`LM_WORD_BITS-1:0]   data_mem_out_wire
);

	word_t        instr;
	word_t        pc_plus4;
	word_t        reg_source;
	word_t        reg_target;
	word_t        reg_dest;
	word_t        a_bus;
	word_t        b_bus;
	word_t        c_alu;
	word_t        mem_data;
	logic [4:0]   rs_index;
	logic [4:0]   rt_index;
	logic [4:0]   rd_index;
	logic [15:0]  imm;
	alu_func_t    alu_func;
	a_source_t    a_source;
	b_source_t    b_source;
	c_source_t    c_source;
	pc_source_t   pc_source;
	branch_func_t branch_func;
	mem_source_t  mem_source;
	logic         reg_write;
	logic         take_branch;

	fetch_unit #(.L(L)) u_fetch (
		.clk(clk), .rst_n(rst_n), .inst_mem_in_wire(inst_mem_in_wire),
		.take_branch(take_branch), .pc_source(pc_source), .reg_source(reg_source),
		.instr(instr), .pc_plus4(pc_plus4)
	);

	control u_control (
		.instr(instr), .rs_index(rs_index), .rt_index(rt_index), .rd_index(rd_index),
		.imm(imm), .alu_func(alu_func), .a_source(a_source), .b_source(b_source),
		.c_source(c_source), .pc_source(pc_source), .branch_func(branch_func),
		.mem_source(mem_source), .reg_write(reg_write)
	);

	reg_bank u_reg_bank (
		.clk(clk), .rst_n(rst_n), .rs_index(rs_index), .rt_index(rt_index),
		.rd_index(rd_index), .reg_write(reg_write), .reg_dest(reg_dest),
		.reg_source(reg_source), .reg_target(reg_target)
	);

	bus_mux u_bus_mux (
		.imm(imm), .shamt(instr[10:6]), .reg_source(reg_source), .reg_target(reg_target),
		.a_source(a_source), .b_source(b_source), .c_alu(c_alu), .mem_data(mem_data),
		.pc_plus4(pc_plus4), .c_source(c_source), .branch_func(branch_func),
		.a_bus(a_bus), .b_bus(b_bus), .reg_dest(reg_dest), .take_branch(take_branch)
	);

	alu u_alu (
		.a_bus(a_bus), .b_bus(b_bus), .alu_func(alu_func), .c_alu(c_alu)
	);

	data_mem #(.L(L)) u_data_mem (
		.clk(clk), .rst_n(rst_n), .data_mem_in_wire(data_mem_in_wire),
		.addr(c_alu), .data_in(reg_target), .mem_source(mem_source),   // Stores write rt
		.mem_data(mem_data), .data_mem_out_wire(data_mem_out_wire)
	);

endmodule

/* verif/lite_mips_tb.sv */
`timescale 1ns/100ps
`include "lite_mips_defs.svh"

module lite_mips_tb import lite_mips_pkg::*; ();

	localparam int L = 6;
	localparam int WORDS = 2**L;
	localparam int N_TESTS = 6;
	localparam int MAX_CHECKS = 8;
	localparam int DONE_TIMEOUT = 200;
	localparam word_t DONE_MARKER = 32'h600d600d;

	logic clk;
	logic rst_n;
	logic [WORDS*`LM_WORD_BITS-1:0] inst_mem_in_wire;
	logic [WORDS*`LM_WORD_BITS-1:0] data_mem_in_wire;
	logic [WORDS*`LM_WORD_BITS-1:0] data_mem_out_wire;

	// ~~~~~~~~~~~~~~~~~~~~
	// Test table
	// ~~~~~~~~~~~~~~~~~~~~
	string test_name [N_TESTS];
	word_t program_image [N_TESTS][WORDS];
	bit    use_seed [N_TESTS];            // Data image comes from the LFSR
	bit    reset_mid_run [N_TESTS];
	int    check_count [N_TESTS];
	int    check_index [N_TESTS][MAX_CHECKS];
	word_t check_value [N_TESTS][MAX_CHECKS];

	word_t       seed_image [WORDS];
	logic [31:0] lfsr_state;
	int          fill_test;
	int          fill_pos;
	int          error_count;
	int          pass_count;
	int          fail_count;

	lite_mips #(.L(L)) u_dut (
		.clk(clk), .rst_n(rst_n), .inst_mem_in_wire(inst_mem_in_wire),
		.data_mem_in_wire(data_mem_in_wire), .data_mem_out_wire(data_mem_out_wire)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Taps 32, 22, 2, 1 give a maximal length sequence
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_word(output word_t w);
		w = '0;
		for (int b = 0; b < 32; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			w = {w[30:0], lfsr_state[0]};
		end
	endtask

	task automatic begin_test(input string name, input bit seeded, input bit mid_reset);
		fill_test++;
		fill_pos = 0;
		test_name[fill_test] = name;
		use_seed[fill_test] = seeded;
		reset_mid_run[fill_test] = mid_reset;
	endtask

	task automatic emit(input word_t w);
		program_image[fill_test][fill_pos] = w;
		fill_pos++;
	endtask

	// Marker goes to word 63, then the program spins on itself
	task automatic emit_finish();
		emit(32'h3c1e600d);               // lui r30, 0x600d
		emit(32'h37de600d);               // ori r30, r30, 0x600d
		emit(32'hac1e00fc);               // sw r30, 252(r0)
		emit(32'h08000000 | word_t'(fill_pos));
	endtask

	task automatic expect_word(input int idx, input word_t value);
		check_index[fill_test][check_count[fill_test]] = idx;
		check_value[fill_test][check_count[fill_test]] = value;
		check_count[fill_test]++;
	endtask

	task automatic build_table();
		fill_test = -1;
		for (int t = 0; t < N_TESTS; t++) begin
			check_count[t] = 0;
			for (int k = 0; k < WORDS; k++) begin
				program_image[t][k] = '0;    // Zero words decode as sll r0, r0, 0
			end
		end
		begin_test("arith_logic", 1'b0, 1'b0);
		emit(32'h3c01ffff);               // lui r1, 0xffff
		emit(32'h3421ffff);               // ori r1, r1, 0xffff
		emit(32'h24020001);               // addiu r2, r0, 1
		emit(32'h3405f0f0);               // ori r5, r0, 0xf0f0
		emit(32'h3c0600ff);               // lui r6, 0x00ff
		emit(32'h34c60ff0);               // ori r6, r6, 0x0ff0
		emit(32'h00221821);               // addu r3, r1, r2
		emit(32'h00022023);               // subu r4, r0, r2
		emit(32'h00a63824);               // and r7, r5, r6
		emit(32'h00a64025);               // or r8, r5, r6
		emit(32'h00a64826);               // xor r9, r5, r6
		emit(32'h00a65027);               // nor r10, r5, r6
		emit(32'h0022582a);               // slt r11, r1, r2
		emit(32'h0022602b);               // sltu r12, r1, r2
		emit(32'hac030000);
		emit(32'hac040004);
		emit(32'hac070008);
		emit(32'hac08000c);
		emit(32'hac090010);
		emit(32'hac0a0014);
		emit(32'hac0b0018);
		emit(32'hac0c001c);
		emit_finish();
		expect_word(0, 32'h00000000);
		expect_word(1, 32'hffffffff);
		expect_word(2, 32'h000000f0);
		expect_word(3, 32'h00fffff0);
		expect_word(4, 32'h00ffff00);
		expect_word(5, 32'hff00000f);
		expect_word(6, 32'h00000001);
		expect_word(7, 32'h00000000);
		begin_test("shifts", 1'b0, 1'b0);
		emit(32'h3c018000);               // lui r1, 0x8000
		emit(32'h34210f00);               // ori r1, r1, 0x0f00
		emit(32'h24050028);               // addiu r5, r0, 40
		emit(32'h00011100);               // sll r2, r1, 4
		emit(32'h00011902);               // srl r3, r1, 4
		emit(32'h00012103);               // sra r4, r1, 4
		emit(32'h00a13004);               // sllv r6, r1, r5
		emit(32'h00a13806);               // srlv r7, r1, r5
		emit(32'h00a14007);               // srav r8, r1, r5
		emit(32'hac020000);
		emit(32'hac030004);
		emit(32'hac040008);
		emit(32'hac06000c);
		emit(32'hac070010);
		emit(32'hac080014);
		emit_finish();
		expect_word(0, 32'h0000f000);
		expect_word(1, 32'h080000f0);
		expect_word(2, 32'hf80000f0);
		expect_word(3, 32'h000f0000);     // Amount 40 acts as 8
		expect_word(4, 32'h0080000f);
		expect_word(5, 32'hff80000f);
		begin_test("immediates", 1'b0, 1'b0);
		emit(32'h2401fff0);               // addiu r1, r0, -16
		emit(32'h30228f0f);               // andi r2, r1, 0x8f0f
		emit(32'h34038001);               // ori r3, r0, 0x8001
		emit(32'h38248000);               // xori r4, r1, 0x8000
		emit(32'h3c05beef);               // lui r5, 0xbeef
		emit(32'h2806ffff);               // slti r6, r0, -1
		emit(32'h2c07ffff);               // sltiu r7, r0, 0xffffffff
		emit(32'hac010000);
		emit(32'hac020004);
		emit(32'hac030008);
		emit(32'hac04000c);
		emit(32'hac050010);
		emit(32'hac060014);
		emit(32'hac070018);
		emit_finish();
		expect_word(0, 32'hfffffff0);
		expect_word(1, 32'h00008f00);
		expect_word(2, 32'h00008001);
		expect_word(3, 32'hffff7ff0);
		expect_word(4, 32'hbeef0000);
		expect_word(5, 32'h00000000);
		expect_word(6, 32'h00000001);
		begin_test("load_store", 1'b1, 1'b0);
		emit(32'h24090020);               // addiu r9, r0, 32
		emit(32'h8c010000);               // lw r1, 0(r0)
		emit(32'h8c020004);
		emit(32'h8c030008);
		emit(32'h8c04000c);
		emit(32'had210000);               // sw r1, 0(r9)
		emit(32'had220004);
		emit(32'had230008);
		emit(32'had24000c);
		emit_finish();
		for (int k = 0; k < 4; k++) begin
			expect_word(8 + k, seed_image[k]);
		end
		expect_word(0, seed_image[0]);
		expect_word(4, seed_image[4]);
		expect_word(12, seed_image[12]);
		expect_word(62, seed_image[62]);
		begin_test("control_flow", 1'b0, 1'b0);
		emit(32'h24010005);               // addiu r1, r0, 5
		emit(32'h24020005);               // addiu r2, r0, 5
		emit(32'h24030007);               // addiu r3, r0, 7
		emit(32'h10220001);               // beq r1, r2, +1 taken
		emit(32'h240a0bad);
		emit(32'h10230001);               // beq r1, r3, +1 not taken
		emit(32'h240b0001);
		emit(32'h14230001);               // bne r1, r3, +1 taken
		emit(32'h240c0bad);
		emit(32'h14220001);               // bne r1, r2, +1 not taken
		emit(32'h240d0001);
		emit(32'h0800000d);               // j 13
		emit(32'hac03001c);               // Skipped store to word 7
		emit(32'h0c00001b);               // jal 27
		emit(32'h24000007);               // addiu r0, r0, 7
		emit(32'h240f0001);               // addiu r15, r0, 1
		emit(32'hac0a0000);
		emit(32'hac0b0004);
		emit(32'hac0c0008);
		emit(32'hac0d000c);
		emit(32'hac1f0010);
		emit(32'hac0f0014);
		emit(32'hac0e0018);
		emit_finish();
		emit(32'h240e0077);               // Subroutine: addiu r14, r0, 0x77
		emit(32'h03e00008);               // jr r31
		expect_word(0, 32'h00000000);
		expect_word(1, 32'h00000001);
		expect_word(2, 32'h00000000);
		expect_word(3, 32'h00000001);
		expect_word(4, 32'h00000038);     // Return address after jal at word 13
		expect_word(5, 32'h00000001);
		expect_word(6, 32'h00000077);
		expect_word(7, 32'h00000000);
		begin_test("reset_mid_run", 1'b1, 1'b1);
		emit(32'h8c010000);               // lw r1, 0(r0)
		emit(32'h24210001);               // addiu r1, r1, 1
		emit(32'hac010000);               // sw r1, 0(r0)
		emit(32'h24020028);               // addiu r2, r0, 40
		emit(32'h2442ffff);               // addiu r2, r2, -1
		emit(32'h1440fffe);               // bne r2, r0, -2
		emit(32'hac020004);               // sw r2, 4(r0)
		emit_finish();
		expect_word(0, seed_image[0] + 32'd1);  // A restart without reload would add 2
		expect_word(1, 32'h00000000);
		expect_word(2, seed_image[2]);
	endtask

	task automatic check_word(input string name, input int idx, input word_t expected,
		input word_t actual);
		if (actual !== expected) begin
			$display("mismatch in %s word %0d: expected %h actual %h",
				name, idx, expected, actual);
			error_count++;
		end
	endtask

	task automatic apply_reset();
		rst_n <= 1'b0;
		for (int i = 0; i < 16; i++) begin
			@(posedge clk);
		end
		rst_n <= 1'b1;
	endtask

	task automatic run_test(input int t);
		logic [WORDS*`LM_WORD_BITS-1:0] code_bus;
		logic [WORDS*`LM_WORD_BITS-1:0] data_bus;
		int cycles;
		int errors_before;
		bit done;
		for (int k = 0; k < WORDS; k++) begin
			code_bus[k*`LM_WORD_BITS +: `LM_WORD_BITS] = program_image[t][k];
			data_bus[k*`LM_WORD_BITS +: `LM_WORD_BITS] = use_seed[t] ? seed_image[k] : '0;
		end
		errors_before = error_count;
		@(posedge clk);
		inst_mem_in_wire <= code_bus;
		data_mem_in_wire <= data_bus;
		apply_reset();
		if (reset_mid_run[t]) begin
			repeat (20) @(posedge clk);    // First increment has landed by now
			apply_reset();
		end
		cycles = 0;
		done = 1'b0;
		while (!done && cycles < DONE_TIMEOUT) begin
			@(negedge clk);
			done = (data_mem_out_wire[(WORDS-1)*`LM_WORD_BITS +: `LM_WORD_BITS] == DONE_MARKER);
			cycles++;
		end
		if (!done) begin
			$display("test %s: program never signalled completion within %0d cycles",
				test_name[t], DONE_TIMEOUT);
			fail_count++;
		end else begin
			for (int c = 0; c < check_count[t]; c++) begin
				check_word(test_name[t], check_index[t][c], check_value[t][c],
					data_mem_out_wire[check_index[t][c]*`LM_WORD_BITS +: `LM_WORD_BITS]);
			end
			if (error_count == errors_before) begin
				$display("test %s: passed after %0d cycles", test_name[t], cycles);
				pass_count++;
			end else begin
				$display("test %s: failed with %0d wrong words", test_name[t],
					error_count - errors_before);
				fail_count++;
			end
		end
	endtask

	initial begin
		rst_n = 1'b0;
		inst_mem_in_wire = '0;
		data_mem_in_wire = '0;
		error_count = 0;
		pass_count = 0;
		fail_count = 0;
		lfsr_state = 32'hcbe5;
		for (int k = 0; k < WORDS - 1; k++) begin
			random_word(seed_image[k]);
		end
		seed_image[WORDS-1] = '0;         // Keeps the done marker out of the seeded image
		build_table();
		for (int t = 0; t < N_TESTS; t++) begin
			run_test(t);
		end
		$display("tests run %0d, passed %0d, failed %0d", N_TESTS, pass_count, fail_count);
		if (fail_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

/* src.f */
+incdir+hdl
hdl/lite_mips_pkg.sv
hdl/fetch_unit.sv
hdl/control.sv
hdl/reg_bank.sv
hdl/bus_mux.sv
hdl/alu.sv
hdl/data_mem.sv
hdl/lite_mips.sv
verif/lite_mips_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the lite_mips testbench with Verilator, runs it and judges the log

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --assert --timing -f src.f --top-module lite_mips_tb -o lite_mips_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/lite_mips_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qF '** FAIL **' "$log"; then
	exit 1
fi
exit 0
